/* hdl/spindle_pkg.sv */
`default_nettype none

package spindle_pkg;

    ////////////////////
    // widths
    ////////////////////

    // lce samples, gains, rates and spike counts
    localparam int word_w = 16;
    // gains are unsigned q8.8
    localparam int frac_bits = 8;
    localparam int sel_w = 3;

    ////////////////////
    // parameter select codes
    ////////////////////

    localparam logic [sel_w-1:0] sel_tick_period = 3'd0;
    localparam logic [sel_w-1:0] sel_lce_rest    = 3'd1;
    localparam logic [sel_w-1:0] sel_gain_i      = 3'd2;
    localparam logic [sel_w-1:0] sel_gain_dyn    = 3'd3;
    localparam logic [sel_w-1:0] sel_gain_ii     = 3'd4;

    ////////////////////
    // reset values
    ////////////////////

    localparam logic [word_w-1:0] tick_period_init = 16'd7;
    localparam logic [word_w-1:0] lce_rest_init    = 16'h1000;
    // 2.0, 8.0 and 1.0 in q8.8
    localparam logic [word_w-1:0] gain_i_init      = 16'h0200;
    localparam logic [word_w-1:0] gain_dyn_init    = 16'h0800;
    localparam logic [word_w-1:0] gain_ii_init     = 16'h0100;

    ////////////////////
    // buffer and window
    ////////////////////

    localparam int fifo_depth = 16;
    localparam int fifo_aw    = 4;
    // rate updates per counting window
    localparam int window_ticks = 8;
    localparam int window_cw    = $clog2(window_ticks + 1);
    // lowest period the host may program
    localparam logic [word_w-1:0] tick_period_min = 16'd3;

endpackage

`default_nettype wire

/* hdl/param_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module param_bank
    import spindle_pkg::*;
(
    input  wire logic              ep50trig,
    input  wire logic              reset_global,
    input  wire logic              param_load,
    input  wire logic [sel_w-1:0]  param_sel,
    input  wire logic [word_w-1:0] param_data,
    output logic      [word_w-1:0] tick_period,
    output logic      [word_w-1:0] lce_rest,
    output logic      [word_w-1:0] gain_i,
    output logic      [word_w-1:0] gain_dyn,
    output logic      [word_w-1:0] gain_ii,
    output logic                   period_load
);

    // period after clamping to the legal floor
    logic [word_w-1:0] period_clamped;

    always_comb
    begin
        if (param_data < tick_period_min)
            period_clamped = tick_period_min;
        else
            period_clamped = param_data;
    end

    ////////////////////
    // parameter registers
    ////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            tick_period <= tick_period_init;
            lce_rest    <= lce_rest_init;
            gain_i      <= gain_i_init;
            gain_dyn    <= gain_dyn_init;
            gain_ii     <= gain_ii_init;
            period_load <= 1'b0;
        end
        else
        begin
            // pulse lines up with the new tick_period value
            period_load <= param_load && (param_sel == sel_tick_period);
            if (param_load)
            begin
                // unknown codes fall through untouched
                case (param_sel)
                    sel_tick_period: tick_period <= period_clamped;
                    sel_lce_rest:    lce_rest    <= param_data;
                    sel_gain_i:      gain_i      <= param_data;
                    sel_gain_dyn:    gain_dyn    <= param_data;
                    sel_gain_ii:     gain_ii     <= param_data;
                    default:         ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/lce_feeder.sv */
`timescale 1ns/1ps
`default_nettype none

module lce_feeder
    import spindle_pkg::*;
(
    input  wire logic              ep50trig,
    input  wire logic              reset_global,
    input  wire logic              lce_write,
    input  wire logic [word_w-1:0] lce_data,
    input  wire logic [word_w-1:0] tick_period,
    input  wire logic              period_load,
    output logic                   fifo_full,
    output logic      [word_w-1:0] lce,
    output logic                   lce_strobe
);

    // sample storage
    logic [word_w-1:0]  mem [fifo_depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    // occupancy, needs one extra bit for full
    logic [fifo_aw:0]   count;

    // timebase
    logic [word_w-1:0]  tick_cnt;
    logic               tick;

    logic               push;
    logic               pop;

    ////////////////////
    // buffer status
    ////////////////////

    assign fifo_full = (count == (fifo_aw + 1)'(fifo_depth));
    // host back-pressure, writes while full are lost
    assign push = lce_write && !fifo_full;
    // empty buffer at a tick just holds lce
    assign pop  = tick && (count != '0);

    ////////////////////
    // tick counter
    ////////////////////

    // counter runs 0..tick_period, so one tick every tick_period+1 cycles
    assign tick = (tick_cnt >= tick_period);

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            tick_cnt <= '0;
        else if (period_load || tick)
            // new period restarts the count
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    ////////////////////
    // buffer storage
    ////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (push)
            mem[wr_ptr] <= lce_data;
    end

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // pointers wrap naturally at fifo_depth
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // sample output
    ////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            lce        <= lce_rest_init;
            lce_strobe <= 1'b0;
        end
        else
        begin
            // strobe comes with the new lce, one cycle after the tick
            lce_strobe <= tick;
            if (pop)
                lce <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* hdl/spindle_rate.sv */
`timescale 1ns/1ps
`default_nettype none

module spindle_rate
    import spindle_pkg::*;
(
    input  wire logic              ep50trig,
    input  wire logic              reset_global,
    input  wire logic [word_w-1:0] lce,
    input  wire logic              lce_strobe,
    input  wire logic [word_w-1:0] lce_rest,
    input  wire logic [word_w-1:0] gain_i,
    input  wire logic [word_w-1:0] gain_dyn,
    input  wire logic [word_w-1:0] gain_ii,
    output logic      [word_w-1:0] ia_rate,
    output logic      [word_w-1:0] ii_rate,
    output logic                   rate_strobe
);

    // lce seen at the last update
    logic [word_w-1:0]           lce_prev;
    logic [word_w-1:0]           stretch;
    logic [word_w-1:0]           velocity;
    logic [2*word_w-1:0]         prod_i;
    logic [2*word_w-1:0]         prod_dyn;
    logic [2*word_w-1:0]         prod_ii;
    logic [2*word_w:0]           ia_sum;
    logic [2*word_w-frac_bits:0] ia_shift;
    logic [2*word_w-frac_bits-1:0] ii_shift;
    logic [word_w-1:0]           ia_sat;
    logic [word_w-1:0]           ii_sat;

    ////////////////////
    // stretch and velocity
    ////////////////////

    always_comb
    begin
        // only lengthening drives the afferents
        stretch  = (lce > lce_rest) ? (lce - lce_rest) : '0;
        velocity = (lce > lce_prev) ? (lce - lce_prev) : '0;

        // q8.8 gain times integer length
        prod_i   = gain_i * stretch;
        prod_dyn = gain_dyn * velocity;
        prod_ii  = gain_ii * stretch;

        ia_sum   = {1'b0, prod_i} + {1'b0, prod_dyn};
        ia_shift = ia_sum[2*word_w:frac_bits];
        ii_shift = prod_ii[2*word_w-1:frac_bits];

        // clip to 65535 on overflow
        ia_sat = (|ia_shift[2*word_w-frac_bits:word_w]) ? '1 : ia_shift[word_w-1:0];
        ii_sat = (|ii_shift[2*word_w-frac_bits-1:word_w]) ? '1 : ii_shift[word_w-1:0];
    end

    ////////////////////
    // rate registers
    ////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            lce_prev    <= lce_rest_init;
            ia_rate     <= '0;
            ii_rate     <= '0;
            rate_strobe <= 1'b0;
        end
        else
        begin
            rate_strobe <= lce_strobe;
            if (lce_strobe)
            begin
                lce_prev <= lce;
                ia_rate  <= ia_sat;
                ii_rate  <= ii_sat;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rate_neuron.sv */
`timescale 1ns/1ps
`default_nettype none

module rate_neuron
    import spindle_pkg::*;
(
    input  wire logic              ep50trig,
    input  wire logic              reset_global,
    input  wire logic [word_w-1:0] rate,
    input  wire logic              rate_strobe,
    output logic                   spike
);

    // phase accumulator, one lap per spike
    logic [word_w-1:0] phase;
    // carry in the top bit
    logic [word_w:0]   phase_next;

    assign phase_next = {1'b0, phase} + {1'b0, rate};

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            phase <= '0;
            spike <= 1'b0;
        end
        else if (rate_strobe)
        begin
            // keep the wrapped sum, fire on carry
            phase <= phase_next[word_w-1:0];
            spike <= phase_next[word_w];
        end
        else
        begin
            spike <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/spike_window.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_window
    import spindle_pkg::*;
(
    input  wire logic              ep50trig,
    input  wire logic              reset_global,
    input  wire logic              rate_strobe,
    input  wire logic              ia_spike,
    input  wire logic              ii_spike,
    output logic      [word_w-1:0] ia_count,
    output logic      [word_w-1:0] ii_count,
    output logic                   count_valid
);

    // strobes seen in the current window
    logic [window_cw-1:0] strobe_cnt;
    logic [word_w-1:0]    ia_run;
    logic [word_w-1:0]    ii_run;
    logic                 latch;

    // strobe after window_ticks earlier ones closes the window
    assign latch = rate_strobe && (strobe_cnt == window_cw'(window_ticks));

    ////////////////////
    // window bookkeeping
    ////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            strobe_cnt <= '0;
        else if (latch)
            // closing strobe opens the next window
            strobe_cnt <= window_cw'(1);
        else if (rate_strobe)
            strobe_cnt <= strobe_cnt + 1'b1;
    end

    ////////////////////
    // spike counters
    ////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            ia_run      <= '0;
            ii_run      <= '0;
            ia_count    <= '0;
            ii_count    <= '0;
            count_valid <= 1'b0;
        end
        else
        begin
            count_valid <= latch;
            if (latch)
            begin
                ia_count <= ia_run;
                ii_count <= ii_run;
                // spikes trail strobes, restart from whatever is present
                ia_run   <= word_w'(ia_spike);
                ii_run   <= word_w'(ii_spike);
            end
            else
            begin
                ia_run <= ia_run + word_w'(ia_spike);
                ii_run <= ii_run + word_w'(ii_spike);
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/spindle_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spindle_top
    import spindle_pkg::*;
(
    input  wire logic              ep50trig,
    input  wire logic              reset_global,
    input  wire logic              param_load,
    input  wire logic [sel_w-1:0]  param_sel,
    input  wire logic [word_w-1:0] param_data,
    input  wire logic              lce_write,
    input  wire logic [word_w-1:0] lce_data,
    output logic                   fifo_full,
    output logic      [word_w-1:0] lce,
    output logic      [word_w-1:0] ia_rate,
    output logic      [word_w-1:0] ii_rate,
    output logic                   rate_strobe,
    output logic                   ia_spike,
    output logic                   ii_spike,
    output logic      [word_w-1:0] ia_count,
    output logic      [word_w-1:0] ii_count,
    output logic                   count_valid
);

    // model parameters
    logic [word_w-1:0] tick_period;
    logic [word_w-1:0] lce_rest;
    logic [word_w-1:0] gain_i;
    logic [word_w-1:0] gain_dyn;
    logic [word_w-1:0] gain_ii;
    logic              period_load;
    logic              lce_strobe;

    ////////////////////
    // input side
    ////////////////////

    param_bank params (
        .ep50trig    (ep50trig),
        .reset_global(reset_global),
        .param_load  (param_load),
        .param_sel   (param_sel),
        .param_data  (param_data),
        .tick_period (tick_period),
        .lce_rest    (lce_rest),
        .gain_i      (gain_i),
        .gain_dyn    (gain_dyn),
        .gain_ii     (gain_ii),
        .period_load (period_load)
    );

    // host samples to one lce per tick
    lce_feeder feeder (
        .ep50trig    (ep50trig),
        .reset_global(reset_global),
        .lce_write   (lce_write),
        .lce_data    (lce_data),
        .tick_period (tick_period),
        .period_load (period_load),
        .fifo_full   (fifo_full),
        .lce         (lce),
        .lce_strobe  (lce_strobe)
    );

    ////////////////////
    // processing
    ////////////////////

    // lce to ia and ii firing rates
    spindle_rate spindle (
        .ep50trig    (ep50trig),
        .reset_global(reset_global),
        .lce         (lce),
        .lce_strobe  (lce_strobe),
        .lce_rest    (lce_rest),
        .gain_i      (gain_i),
        .gain_dyn    (gain_dyn),
        .gain_ii     (gain_ii),
        .ia_rate     (ia_rate),
        .ii_rate     (ii_rate),
        .rate_strobe (rate_strobe)
    );

    // primary afferent
    rate_neuron ia_neuron (
        .ep50trig    (ep50trig),
        .reset_global(reset_global),
        .rate        (ia_rate),
        .rate_strobe (rate_strobe),
        .spike       (ia_spike)
    );

    // secondary afferent
    rate_neuron ii_neuron (
        .ep50trig    (ep50trig),
        .reset_global(reset_global),
        .rate        (ii_rate),
        .rate_strobe (rate_strobe),
        .spike       (ii_spike)
    );

    ////////////////////
    // output side
    ////////////////////

    spike_window window (
        .ep50trig    (ep50trig),
        .reset_global(reset_global),
        .rate_strobe (rate_strobe),
        .ia_spike    (ia_spike),
        .ii_spike    (ii_spike),
        .ia_count    (ia_count),
        .ii_count    (ii_count),
        .count_valid (count_valid)
    );

endmodule

`default_nettype wire

/* testbench/tb_spindle.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spindle
    import spindle_pkg::*;
();

    logic              ep50trig;
    logic              reset_global;
    logic              param_load;
    logic [sel_w-1:0]  param_sel;
    logic [word_w-1:0] param_data;
    logic              lce_write;
    logic [word_w-1:0] lce_data;
    wire logic              fifo_full;
    wire logic [word_w-1:0] lce;
    wire logic [word_w-1:0] ia_rate;
    wire logic [word_w-1:0] ii_rate;
    wire logic              rate_strobe;
    wire logic              ia_spike;
    wire logic              ii_spike;
    wire logic [word_w-1:0] ia_count;
    wire logic [word_w-1:0] ii_count;
    wire logic              count_valid;

    // pattern lines without comments
    string       lines[$];
    string       test_name = "setup";
    // cycle budget, zero until the pattern file is scanned
    int unsigned limit = 0;
    int unsigned cycles = 0;

    spindle_top UUT (
        .ep50trig    (ep50trig),
        .reset_global(reset_global),
        .param_load  (param_load),
        .param_sel   (param_sel),
        .param_data  (param_data),
        .lce_write   (lce_write),
        .lce_data    (lce_data),
        .fifo_full   (fifo_full),
        .lce         (lce),
        .ia_rate     (ia_rate),
        .ii_rate     (ii_rate),
        .rate_strobe (rate_strobe),
        .ia_spike    (ia_spike),
        .ii_spike    (ii_spike),
        .ia_count    (ia_count),
        .ii_count    (ii_count),
        .count_valid (count_valid)
    );

    ////////////////////
    // clock and timeout
    ////////////////////

    // 100 ns period
    initial
    begin
        ep50trig = 1'b0;
        forever #50 ep50trig = ~ep50trig;
    end

    always @(posedge ep50trig)
    begin
        cycles++;
        if (limit != 0 && cycles >= limit)
        begin
            $display("Timeout in %s: an expected strobe never arrived", test_name);
            $display("Regression failed");
            $fatal(1);
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic check_value(input string what, input logic [word_w-1:0] expected,
                               input logic [word_w-1:0] actual);
        if (expected !== actual)
        begin
            $display("Mismatch in %s: %s expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // drop line ending and trailing blanks
    function automatic string trim_line(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t.getc(t.len() - 1) == "\n" || t.getc(t.len() - 1) == "\r"
               || t.getc(t.len() - 1) == " "))
            t = t.substr(0, t.len() - 2);
        return t;
    endfunction

    // one-cycle load strobe, no idle gap so tick timing stays fixed
    task automatic write_param(input logic [sel_w-1:0] sel, input logic [word_w-1:0] data);
        @(posedge ep50trig);
        param_load <= 1'b1;
        param_sel  <= sel;
        param_data <= data;
        @(posedge ep50trig);
        param_load <= 1'b0;
    endtask

    // random idle gap of 0..3 cycles before each sample
    task automatic write_lce(input logic [word_w-1:0] data);
        int unsigned gap;
        gap = $urandom_range(3, 0);
        repeat (gap) @(posedge ep50trig);
        @(posedge ep50trig);
        lce_write <= 1'b1;
        lce_data  <= data;
        @(posedge ep50trig);
        lce_write <= 1'b0;
    endtask

    // outputs are read on the falling edge
    task automatic wait_rate_strobe();
        do @(negedge ep50trig); while (rate_strobe !== 1'b1);
    endtask

    task automatic wait_count_valid();
        do @(negedge ep50trig); while (count_valid !== 1'b1);
    endtask

    // cycles from one rate_strobe to the next
    task automatic measure_interval(output int n);
        wait_rate_strobe();
        n = 0;
        do
        begin
            @(negedge ep50trig);
            n++;
        end
        while (rate_strobe !== 1'b1);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        int                fd;
        string             line;
        string             args;
        byte               cmd;
        logic [word_w-1:0] a;
        logic [word_w-1:0] b;
        logic [word_w-1:0] c;
        int                n;
        int unsigned       runs;
        int unsigned       expects;

        reset_global = 1'b1;
        param_load   = 1'b0;
        param_sel    = '0;
        param_data   = '0;
        lce_write    = 1'b0;
        lce_data     = '0;
        runs         = 0;
        expects      = 0;
        void'($urandom(32'h30af_f688));

        fd = $fopen("testbench/spindle_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the pattern file testbench/spindle_patterns.txt");
            $display("Regression failed");
            $fatal(1);
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                if ($fgets(line, fd) != 0)
                begin
                    line = trim_line(line);
                    if (line.len() > 2 && line.getc(0) != "#")
                        lines.push_back(line);
                end
            end
            $fclose(fd);

            // budget: run lengths plus 16 cycles per expectation
            foreach (lines[i])
            begin
                cmd  = lines[i].getc(0);
                args = lines[i].substr(2, lines[i].len() - 1);
                if (cmd == "T")
                begin
                    void'($sscanf(args, "%d", n));
                    runs += n;
                end
                else if (cmd == "R" || cmd == "C" || cmd == "F" || cmd == "D")
                    expects++;
            end
            limit = runs + 16 * expects;

            repeat (16) @(posedge ep50trig);
            reset_global <= 1'b0;
            @(negedge ep50trig);

            // everything quiet straight out of reset
            test_name = "reset";
            check_value("fifo_full", '0, word_w'(fifo_full));
            check_value("ia_rate", '0, ia_rate);
            check_value("ii_rate", '0, ii_rate);
            check_value("rate_strobe", '0, word_w'(rate_strobe));
            check_value("ia_spike", '0, word_w'(ia_spike));
            check_value("ii_spike", '0, word_w'(ii_spike));
            check_value("ia_count", '0, ia_count);
            check_value("ii_count", '0, ii_count);
            check_value("count_valid", '0, word_w'(count_valid));

            foreach (lines[i])
            begin
                cmd  = lines[i].getc(0);
                args = lines[i].substr(2, lines[i].len() - 1);
                case (cmd)
                    "N": test_name = args;
                    "P":
                    begin
                        void'($sscanf(args, "%h %h", a, b));
                        write_param(a[sel_w-1:0], b);
                    end
                    "W":
                    begin
                        void'($sscanf(args, "%h", a));
                        write_lce(a);
                    end
                    "R":
                    begin
                        void'($sscanf(args, "%h %h %h", a, b, c));
                        wait_rate_strobe();
                        check_value("lce", a, lce);
                        check_value("ia_rate", b, ia_rate);
                        check_value("ii_rate", c, ii_rate);
                    end
                    "C":
                    begin
                        void'($sscanf(args, "%h %h", a, b));
                        wait_count_valid();
                        check_value("ia_count", a, ia_count);
                        check_value("ii_count", b, ii_count);
                    end
                    "F":
                    begin
                        void'($sscanf(args, "%h", a));
                        @(negedge ep50trig);
                        check_value("fifo_full", a, word_w'(fifo_full));
                    end
                    "T":
                    begin
                        void'($sscanf(args, "%d", n));
                        repeat (n) @(posedge ep50trig);
                    end
                    "D":
                    begin
                        void'($sscanf(args, "%d", n));
                        a = word_w'(n);
                        measure_interval(n);
                        check_value("strobe interval", a, word_w'(n));
                    end
                    default:
                    begin
                        $display("Unknown command in pattern file: %s", lines[i]);
                        $display("Regression failed");
                        $fatal(1);
                    end
                endcase
            end

            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* testbench/spindle_patterns.txt */
# N name | P sel data | W lce | R lce ia_rate ii_rate | C ia_count ii_count | F fifo_full
# values in hex, except T cycles and D strobe interval in decimal
N reset_defaults
F 0
R 1000 0000 0000
N spike_counts
P 1 0f00
P 2 5000
P 4 3000
R 1000 5000 3000
T 40
C 0002 0001
T 48
C 0002 0001
N rate_rule
P 0 0200
P 1 1000
P 2 0200
P 4 0100
W 1010
W 1030
W 1020
W 1050
T 8
P 0 0007
R 1010 00a0 0010
R 1030 0160 0030
R 1020 0040 0020
R 1050 0220 0050
N buffer_hold
R 1050 00a0 0050
N saturation
P 1 0000
P 2 ffff
P 4 ffff
T 10
R 1050 ffff ffff
N fifo_full
P 0 0200
W 2001
W 2002
W 2003
W 2004
W 2005
W 2006
W 2007
W 2008
W 2009
W 200a
W 200b
W 200c
W 200d
W 200e
W 200f
W 2010
W 2011
F 1
T 8
P 0 0007
R 2001 ffff ffff
R 2002 ffff ffff
R 2003 ffff ffff
R 2004 ffff ffff
R 2005 ffff ffff
R 2006 ffff ffff
R 2007 ffff ffff
R 2008 ffff ffff
R 2009 ffff ffff
R 200a ffff ffff
R 200b ffff ffff
R 200c ffff ffff
R 200d ffff ffff
R 200e ffff ffff
R 200f ffff ffff
R 2010 ffff ffff
R 2010 ffff ffff
F 0
N tick_period
P 0 0004
T 20
D 5
P 0 0001
T 20
D 4

/* vlog.f */
hdl/spindle_pkg.sv
hdl/param_bank.sv
hdl/lce_feeder.sv
hdl/spindle_rate.sv
hdl/rate_neuron.sv
hdl/spike_window.sv
hdl/spindle_top.sv
testbench/tb_spindle.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary -f vlog.f --top-module tb_spindle -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_spindle)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Regression passed"; then
    exit 0
else
    exit 1
fi
